/* cacheLookup.sv */
module cacheLookup
    import memPkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  memReq_t      req,
    input  memResp_t     fill,
    input  storeCommit_t commit,
    output memResp_t     hitResp,
    output memReq_t      missReq
);

    logic                 lineValid [CacheLines];
    logic [TagBits-1:0]   lineTag   [CacheLines];
    logic [15:0]          lineData  [CacheLines];

    logic [IndexBits-1:0] reqIdx;
    logic [TagBits-1:0]   reqTag;
    logic                 isHit;

    logic [IndexBits-1:0] fillIdx;
    logic [TagBits-1:0]   fillTag;
    logic [IndexBits-1:0] cmtIdx;
    logic [TagBits-1:0]   cmtTag;
    logic                 cmtMatch;

    logic                 hitValid;
    logic [AddrWidth-1:0] hitPc;
    logic [AddrWidth-1:0] hitAddr;
    logic [15:0]          hitData;

    assign reqIdx  = req.addr[IndexBits:1];
    assign reqTag  = req.addr[IndexBits+TagBits:IndexBits+1];
    assign fillIdx = fill.addr[IndexBits:1];
    assign fillTag = fill.addr[IndexBits+TagBits:IndexBits+1];
    assign cmtIdx  = commit.addr[IndexBits:1];
    assign cmtTag  = commit.addr[IndexBits+TagBits:IndexBits+1];

    assign isHit    = (req.op == OpLoad) && lineValid[reqIdx] && (lineTag[reqIdx] == reqTag);
    assign cmtMatch = commit.valid && lineValid[cmtIdx] && (lineTag[cmtIdx] == cmtTag);

    // Everything except a load hit goes down the miss path.
    always_comb begin
        missReq    = req;
        missReq.op = OpNone;
        unique case (req.op)
            OpLoad:      missReq.op = isHit ? OpNone : OpLoad;
            OpStoreHalf: missReq.op = OpStoreHalf;
            OpStoreByte: missReq.op = OpStoreByte;
            default:     missReq.op = OpNone;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hitValid <= 1'b0;
        end else begin
            hitValid <= isHit;
        end
    end

    always_ff @(posedge clk) begin
        hitPc   <= req.pc;
        hitAddr <= req.addr;
        hitData <= lineData[reqIdx];
    end

    assign hitResp = '{valid: hitValid,
                       pc:    hitPc,
                       addr:  hitAddr,
                       data:  {{(DataWidth-16){1'b0}}, hitData}};

    // Stores never allocate, so only fills set a line valid.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < CacheLines; i++) begin
                lineValid[i] <= 1'b0;
            end
        end else if (fill.valid) begin
            lineValid[fillIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            lineTag[fillIdx]  <= fillTag;
            lineData[fillIdx] <= fill.data[15:0];
        end
        // Commit last so it wins on a shared line.
        if (cmtMatch) begin
            if (!commit.isByte) begin
                lineData[cmtIdx] <= commit.data;
            end else if (commit.addr[0]) begin
                lineData[cmtIdx][15:8] <= commit.data[7:0]; // Upper byte.
            end else begin
                lineData[cmtIdx][7:0] <= commit.data[7:0];
            end
        end
    end

endmodule

/* dataMemory.sv */
module dataMemory
    import memPkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  memReq_t      memReq,
    output memResp_t     memResp,
    output storeCommit_t commit
);

    logic [7:0]                 mem [MemBytes];
    logic [IndexBits+TagBits:0] byteAddr;
    logic [IndexBits+TagBits:0] loAddr;
    logic [IndexBits+TagBits:0] hiAddr;

    logic                 respValid;
    logic [AddrWidth-1:0] respPc;
    logic [AddrWidth-1:0] respAddr;
    logic [15:0]          respData;

    logic                 cmtValid;
    logic [AddrWidth-1:0] cmtAddr;
    logic [15:0]          cmtData;
    logic                 cmtIsByte;

    assign byteAddr = memReq.addr[IndexBits+TagBits:0];
    assign loAddr   = {byteAddr[IndexBits+TagBits:1], 1'b0}; // Halfword aligned.
    assign hiAddr   = {byteAddr[IndexBits+TagBits:1], 1'b1};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < MemBytes; i++) begin
                mem[i] <= 8'h00;
            end
            respValid <= 1'b0;
            cmtValid  <= 1'b0;
        end else begin
            respValid <= 1'b0;
            cmtValid  <= 1'b0;
            unique case (memReq.op)
                OpLoad: begin
                    respValid <= 1'b1;
                end
                OpStoreHalf: begin
                    mem[loAddr] <= memReq.data[7:0];
                    mem[hiAddr] <= memReq.data[15:8];
                    cmtValid    <= 1'b1;
                end
                OpStoreByte: begin
                    mem[byteAddr] <= memReq.data[7:0]; // Exact byte.
                    cmtValid      <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        respPc    <= memReq.pc;
        respAddr  <= memReq.addr;
        respData  <= {mem[hiAddr], mem[loAddr]}; // Little-endian.
        cmtAddr   <= memReq.addr;
        cmtData   <= memReq.data[15:0];
        cmtIsByte <= (memReq.op == OpStoreByte);
    end

    assign memResp = '{valid: respValid,
                       pc:    respPc,
                       addr:  respAddr,
                       data:  {{(DataWidth-16){1'b0}}, respData}};

    assign commit = '{valid:  cmtValid,
                      addr:   cmtAddr,
                      data:   cmtData,
                      isByte: cmtIsByte};

endmodule

/* memHier.f */
memPkg.sv
cacheLookup.sv
missDelayLine.sv
dataMemory.sv
memHierarchy.sv
memHierTb.sv

/* memHierTb.sv */
module memHierTb
    import memPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RespTimeout = 50;     // Cycles a load may stay open.
    localparam int StoreGap    = 12;     // Commit reaches the cache by then.
    localparam logic [31:0] WinBase = 32'h040;

    typedef enum logic [1:0] {
        PortAny,
        PortHit,
        PortMem
    } port_e;

    typedef struct packed {
        logic [15:0] data;
        logic [31:0] addr;
        int          issueEdge;
        int          latency;   // Negative means any latency.
        port_e       port;
    } expEntry_t;

    logic     clk = 1'b0;
    logic     rstn;
    memReq_t  req;
    memResp_t hitResp;
    memResp_t memResp;

    int          cycleCnt = 0;
    logic [31:0] pcNext   = 32'h1000;
    logic [31:0] lastPc;
    string       testName = "reset";
    logic [7:0]  mirror    [MemBytes];
    int          lastStore [MemBytes/2]; // Issue edge per halfword.
    expEntry_t   sb        [logic [31:0]];

    memHierarchy u_dut (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .hitResp (hitResp),
        .memResp (memResp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    function automatic logic [15:0] refHalf(input logic [31:0] addr);
        return {mirror[{addr[9:1], 1'b1}], mirror[{addr[9:1], 1'b0}]}; // Little-endian.
    endfunction

    task automatic checkResp(input string name, input memResp_t exp, input memResp_t act);
        if (act !== exp) begin
            stopOnError($sformatf("FAILED %s pc %h: expected addr %h data %h, actual addr %h data %h",
                                  name, act.pc, exp.addr, exp.data, act.addr, act.data));
        end
    endtask

    task automatic checkLatency(input string name, input int exp, input int act);
        if (act != exp) begin
            stopOnError($sformatf("FAILED %s latency: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic matchResp(input port_e port, input memResp_t act);
        expEntry_t e;
        memResp_t  exp;
        if (!sb.exists(act.pc)) begin
            stopOnError($sformatf("A response arrived on the %s port for unknown pc %h.",
                                  port.name(), act.pc));
        end else begin
            e   = sb[act.pc];
            exp = '{valid: 1'b1, pc: act.pc, addr: e.addr, data: {16'h0000, e.data}};
            checkResp(testName, exp, act);
            if (e.port != PortAny && e.port != port) begin
                stopOnError($sformatf("Load with pc %h came back on the %s port instead of %s.",
                                      act.pc, port.name(), e.port.name()));
            end
            if (e.latency >= 0) begin
                checkLatency(testName, e.latency, cycleCnt - e.issueEdge);
            end
            sb.delete(act.pc);
        end
    endtask

    // Scoreboard samples away from the driving edge.
    always @(negedge clk) begin
        if (rstn) begin
            if (hitResp.valid) matchResp(PortHit, hitResp);
            if (memResp.valid) matchResp(PortMem, memResp);
            foreach (sb[k]) begin
                if (cycleCnt - sb[k].issueEdge > RespTimeout) begin
                    stopOnError($sformatf("Load with pc %h got no response in %0d cycles.",
                                          k, RespTimeout));
                end
            end
        end
    end

    // Called right after a rising edge; the edge itself counts as issue.
    task automatic driveReq(input memOp_e op, input logic [31:0] addr, input logic [15:0] data,
                            input port_e port, input int latency);
        expEntry_t e;
        req <= '{op: op, pc: pcNext, addr: addr, data: {16'h0000, data}};
        case (op)
            OpLoad: begin
                e = '{data: refHalf(addr), addr: addr, issueEdge: cycleCnt + 1,
                      latency: latency, port: port};
                sb[pcNext] = e;
            end
            OpStoreHalf: begin
                mirror[{addr[9:1], 1'b0}] = data[7:0];
                mirror[{addr[9:1], 1'b1}] = data[15:8];
                lastStore[addr[9:1]]      = cycleCnt + 1;
            end
            OpStoreByte: begin
                mirror[addr[9:0]]    = data[7:0];
                lastStore[addr[9:1]] = cycleCnt + 1;
            end
            default: ;
        endcase
        lastPc = pcNext;
        pcNext = pcNext + 32'd4;
    endtask

    task automatic issueReq(input memOp_e op, input logic [31:0] addr, input logic [15:0] data,
                            input port_e port, input int latency);
        @(posedge clk);
        driveReq(op, addr, data, port, latency);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            req.op <= OpNone;
        end
    endtask

    task automatic waitResp(input logic [31:0] pc);
        int cycles;
        cycles = 0;
        while (sb.exists(pc) && cycles < RespTimeout) begin
            @(posedge clk);
            req.op <= OpNone;
            cycles++;
        end
        if (sb.exists(pc)) begin
            stopOnError($sformatf("No response for the load with pc %h after %0d cycles.",
                                  pc, RespTimeout));
        end
    endtask

    task automatic loadAndWait(input logic [31:0] addr, input port_e port, input int latency);
        issueReq(OpLoad, addr, 16'h0000, port, latency);
        waitResp(lastPc);
    endtask

    task automatic randomStream(input int count);
        logic [31:0] addr;
        int unsigned kind;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            addr = WinBase + ($urandom % 64);
            kind = $urandom % 4;
            if (kind < 2 && (cycleCnt + 1) - lastStore[addr[9:1]] >= StoreGap) begin
                driveReq(OpLoad, addr, 16'h0000, PortAny, -1);
            end else if (kind == 3) begin
                driveReq(OpStoreByte, addr, 16'($urandom), PortAny, -1);
            end else begin
                driveReq(OpStoreHalf, addr, 16'($urandom), PortAny, -1); // Also covers blocked loads.
            end
        end
    endtask

    task automatic drainAll();
        int cycles;
        cycles = 0;
        while (sb.num() != 0 && cycles < RespTimeout) begin
            @(posedge clk);
            req.op <= OpNone;
            cycles++;
        end
    endtask

    initial begin
        void'($urandom(32'h209d_ddbd));
        req  <= '0;
        rstn <= 1'b0;
        for (int i = 0; i < MemBytes; i++) mirror[i] = 8'h00;
        for (int i = 0; i < MemBytes / 2; i++) lastStore[i] = -1000;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        idle(2);

        testName = "resetMiss";
        loadAndWait(32'h2a4, PortMem, 11);
        testName = "refillHit";
        loadAndWait(32'h2a4, PortHit, 1);

        testName = "storeMerge";
        issueReq(OpStoreHalf, 32'h0c0, 16'hbeef, PortAny, -1);
        issueReq(OpStoreByte, 32'h0c3, 16'h005a, PortAny, -1);
        idle(StoreGap);
        loadAndWait(32'h0c0, PortAny, -1);
        loadAndWait(32'h0c2, PortAny, -1);

        testName = "commitUpdate";
        issueReq(OpStoreHalf, 32'h2a4, 16'h1234, PortAny, -1);
        idle(StoreGap);
        loadAndWait(32'h2a4, PortHit, 1);

        testName = "eviction";       // Same index 2 with tags 0x0a and 0x1a.
        loadAndWait(32'h144, PortMem, -1);
        loadAndWait(32'h344, PortMem, -1);
        loadAndWait(32'h144, PortMem, -1);

        testName = "randomStream";
        randomStream(300);
        drainAll();
        idle(2);

        if (sb.num() != 0) begin
            stopOnError($sformatf("Scoreboard still holds %0d loads at the end.", sb.num()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* memHierarchy.sv */
module memHierarchy
    import memPkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  memReq_t  req,
    output memResp_t hitResp,
    output memResp_t memResp
);

    memReq_t      missReq;
    memReq_t      memReq;
    storeCommit_t commit;

    cacheLookup u_cache (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .fill    (memResp), // Load responses refill the cache.
        .commit  (commit),
        .hitResp (hitResp),
        .missReq (missReq)
    );

    missDelayLine u_delay (
        .clk  (clk),
        .rstn (rstn),
        .in   (missReq),
        .out  (memReq)
    );

    dataMemory u_mem (
        .clk     (clk),
        .rstn    (rstn),
        .memReq  (memReq),
        .memResp (memResp),
        .commit  (commit)
    );

endmodule

/* memPkg.sv */
package memPkg;

    localparam int MemBytes    = 1024; // Backing store size.
    localparam int AddrWidth   = 32;
    localparam int DataWidth   = 32;
    localparam int MissLatency = 10;   // Delay stages before memory.
    localparam int CacheLines  = 16;   // One halfword per line.
    localparam int IndexBits   = 4;    // Address bits 4..1.
    localparam int TagBits     = 5;    // Address bits 9..5.

    typedef enum logic [1:0] {
        OpNone,
        OpLoad,
        OpStoreHalf,
        OpStoreByte
    } memOp_e;

    // A request is live whenever op is not OpNone.
    typedef struct packed {
        memOp_e               op;
        logic [AddrWidth-1:0] pc;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data; // Stores use the low halfword.
    } memReq_t;

    typedef struct packed {
        logic                 valid;
        logic [AddrWidth-1:0] pc;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data; // Halfword, zero-extended.
    } memResp_t;

    typedef struct packed {
        logic                 valid;
        logic [AddrWidth-1:0] addr;
        logic [15:0]          data;
        logic                 isByte; // Only the addressed byte changed.
    } storeCommit_t;

endpackage

/* missDelayLine.sv */
module missDelayLine
    import memPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  memReq_t in,
    output memReq_t out
);

    memOp_e  opStage  [MissLatency];
    memReq_t reqStage [MissLatency]; // Op field here is not used.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < MissLatency; i++) begin
                opStage[i] <= OpNone;
            end
        end else begin
            opStage[0] <= in.op;
            for (int i = 1; i < MissLatency; i++) begin
                opStage[i] <= opStage[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        reqStage[0] <= in;
        for (int i = 1; i < MissLatency; i++) begin
            reqStage[i] <= reqStage[i-1];
        end
    end

    // Oldest entry feeds the memory.
    always_comb begin
        out    = reqStage[MissLatency-1];
        out.op = opStage[MissLatency-1];
    end

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Builds the memory hierarchy testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module memHierTb -f memHier.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

simOut=$(./obj_dir/VmemHierTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus."
    exit 1
fi

if echo "$simOut" | grep -Fqx '>>> PASS'; then
    exit 0
fi

echo "Pass message not found in the simulation output."
exit 1
